// File: common/apbPkg.sv
`default_nettype none

package apbPkg;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;

    // slot field of paddr, one 4 KB window per slave
    localparam int SLOT_MSB = 15;
    localparam int SLOT_LSB = 12;
    localparam int SLOT_WIDTH = SLOT_MSB - SLOT_LSB + 1;

    localparam int REG_ADDR_WIDTH = 5;  // word offset, paddr[6:2]

    typedef logic [SLOT_WIDTH-1:0] slotT;

    localparam slotT TIM2_SLOT = 4'd1;
    localparam slotT TIM3_SLOT = 4'd2;

endpackage

`default_nettype wire

// File: common/timerPkg.sv
`default_nettype none

package timerPkg;

    localparam int REG_WIDTH = 16;

    typedef logic [apbPkg::REG_ADDR_WIDTH-1:0] regOfsT;

    // word offsets inside one timer
    localparam regOfsT CR1_OFS = 5'd0;
    localparam regOfsT DIER_OFS = 5'd3;
    localparam regOfsT SR_OFS = 5'd4;
    localparam regOfsT EGR_OFS = 5'd5;
    localparam regOfsT CCMR1_OFS = 5'd6;
    localparam regOfsT CCMR2_OFS = 5'd7;
    localparam regOfsT CCER_OFS = 5'd8;
    localparam regOfsT CNT_OFS = 5'd9;
    localparam regOfsT PSC_OFS = 5'd10;
    localparam regOfsT ARR_OFS = 5'd11;
    localparam regOfsT CCR1_OFS = 5'd13;
    localparam regOfsT CCR2_OFS = 5'd14;
    localparam regOfsT CCR3_OFS = 5'd15;
    localparam regOfsT CCR4_OFS = 5'd16;

    localparam logic [REG_WIDTH-1:0] ARR_RESET = '1;

    localparam int CEN_BIT = 0;  // CR1
    localparam int DIR_BIT = 4;  // CR1, 1 = down
    localparam int CKD_LSB = 8;  // CR1, 2 bits
    localparam int UIE_BIT = 0;  // DIER
    localparam int UIF_BIT = 0;  // SR
    localparam int UG_BIT = 0;  // EGR
    localparam int OCM_LSB = 4;  // inside each channel byte of CCMR
    localparam int CCE_BIT = 0;  // inside each channel nibble of CCER
    localparam int CCP_BIT = 1;

    // any other OCxM value drives the raw level low
    typedef enum logic [2:0] {
        OC_PWM1 = 3'd6,
        OC_PWM2 = 3'd7
    } ocModeT;

    typedef struct packed {
        logic                 enable;
        logic                 dir;
        logic [1:0]           ckd;
        logic [REG_WIDTH-1:0] psc;
        logic [REG_WIDTH-1:0] arr;
        logic                 cntLoad;  // one cycle, software write to CNT
        logic [REG_WIDTH-1:0] cntLoadValue;
        logic                 forceUpdate;  // one cycle, EGR.UG
    } timerCfgT;

endpackage

`default_nettype wire

// File: common/apbSlaveIf.sv
`timescale 1ns/100ps
`default_nettype none

interface apbSlaveIf;

    logic [apbPkg::REG_ADDR_WIDTH-1:0] addr;  // word offset
    logic                              sel;
    logic                              enable;
    logic                              write;
    logic [apbPkg::DATA_WIDTH-1:0]     wdata;
    logic [apbPkg::DATA_WIDTH-1:0]     rdata;
    logic                              ready;
    logic                              slvErr;

    modport router (
        output addr, sel, enable, write, wdata,
        input  rdata, ready, slvErr
    );

    modport timer (
        input  addr, sel, enable, write, wdata,
        output rdata, ready, slvErr
    );

endinterface

`default_nettype wire

// File: timer/timerCounter.sv
`timescale 1ns/100ps
`default_nettype none

module timerCounter (
    input  wire                    io_apb_PCLK,
    input  wire                    io_apb_PRESET,
    input  var timerPkg::timerCfgT cfg,
    output logic [15:0]            cnt,
    output logic                   updateEvent
);

    logic [1:0]  divCnt;
    logic [1:0]  divLast;  // divide ratio minus one
    logic [15:0] pscCnt;
    logic        divTick;
    logic        step;
    logic        atLimit;

    always_comb begin
        case (cfg.ckd)
            2'd1:    divLast = 2'd1;
            2'd2:    divLast = 2'd3;
            default: divLast = 2'd0;  // CKD 3 behaves as 0
        endcase
    end

    assign divTick = (divCnt == divLast);
    assign step = cfg.enable && divTick && (pscCnt >= cfg.psc);
    assign atLimit = cfg.dir ? (cnt == '0) : (cnt == cfg.arr);

    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            divCnt <= '0;
            pscCnt <= '0;
            cnt <= '0;
            updateEvent <= 1'b0;
        end else begin
            updateEvent <= 1'b0;
            if (!cfg.enable) begin
                divCnt <= '0;
                pscCnt <= '0;
            end else if (divTick) begin
                divCnt <= '0;
                pscCnt <= (pscCnt >= cfg.psc) ? '0 : pscCnt + 1'b1;
            end else begin
                divCnt <= divCnt + 1'b1;
            end

            if (cfg.forceUpdate) begin
                cnt <= cfg.dir ? cfg.arr : '0;
                pscCnt <= '0;
                updateEvent <= 1'b1;
            end else if (cfg.cntLoad) begin
                cnt <= cfg.cntLoadValue;
            end else if (step) begin
                if (atLimit) begin
                    cnt <= cfg.dir ? cfg.arr : '0;  // reload and flag
                    updateEvent <= 1'b1;
                end else begin
                    cnt <= cfg.dir ? cnt - 1'b1 : cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: timer/timerCompareOut.sv
`timescale 1ns/100ps
`default_nettype none

module timerCompareOut #(
    parameter int channelCount = 4
) (
    input  wire [15:0] cnt,
    input  wire        dir,
    input  wire [31:0] ccmr,
    input  wire [15:0] ccer,
    input  wire [63:0] ccr,
    output wire [3:0]  ch
);

    for (genvar i = 0; i < 4; i++) begin : gChannel
        if (i < channelCount) begin : gActive
            logic [15:0] ccrI;
            logic        pwm1;  // mode 1 level for the current direction
            logic        raw;

            assign ccrI = ccr[16*i +: 16];
            assign pwm1 = dir ? (cnt <= ccrI) : (cnt < ccrI);

            always_comb begin
                case (timerPkg::ocModeT'(ccmr[8*i + timerPkg::OCM_LSB +: 3]))
                    timerPkg::OC_PWM1: raw = pwm1;
                    timerPkg::OC_PWM2: raw = !pwm1;
                    default:           raw = 1'b0;
                endcase
                if (!ccer[4*i + timerPkg::CCE_BIT]) begin
                    raw = 1'b0;
                end
            end

            assign ch[i] = raw ^ ccer[4*i + timerPkg::CCP_BIT];  // polarity
        end else begin : gUnused
            assign ch[i] = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: timer/timerRegs.sv
`timescale 1ns/100ps
`default_nettype none

module timerRegs (
    input  wire                io_apb_PCLK,
    input  wire                io_apb_PRESET,
    input  wire  [15:0]        cnt,
    input  wire                updateEvent,
    apbSlaveIf.timer           bus,
    output timerPkg::timerCfgT cfg,
    output logic [31:0]        ccmr,
    output logic [15:0]        ccer,
    output logic [63:0]        ccr,
    output logic               interrupt
);

    localparam int W = timerPkg::REG_WIDTH;

    logic [W-1:0] cr1;
    logic [W-1:0] dier;
    logic         uif;  // only SR bit kept
    logic [W-1:0] ccmr1;
    logic [W-1:0] ccmr2;
    logic [W-1:0] ccerQ;
    logic [W-1:0] psc;
    logic [W-1:0] arr;
    logic [W-1:0] ccrQ [4];
    logic         wrEn;
    logic         rdEn;
    logic [W-1:0] wdata16;
    logic [W-1:0] rdValue;

    assign wrEn = bus.sel && bus.enable && bus.write;
    assign rdEn = bus.sel && bus.enable && !bus.write;
    assign wdata16 = bus.wdata[W-1:0];

    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            cr1 <= '0;
            dier <= '0;
            uif <= 1'b0;
            ccmr1 <= '0;
            ccmr2 <= '0;
            ccerQ <= '0;
            psc <= '0;
            arr <= timerPkg::ARR_RESET;
            ccrQ <= '{default: '0};
        end else begin
            if (wrEn) begin
                case (bus.addr)
                    timerPkg::CR1_OFS:   cr1 <= wdata16;
                    timerPkg::DIER_OFS:  dier <= wdata16;
                    timerPkg::SR_OFS:    uif <= wdata16[timerPkg::UIF_BIT];
                    timerPkg::CCMR1_OFS: ccmr1 <= wdata16;
                    timerPkg::CCMR2_OFS: ccmr2 <= wdata16;
                    timerPkg::CCER_OFS:  ccerQ <= wdata16;
                    timerPkg::PSC_OFS:   psc <= wdata16;
                    timerPkg::ARR_OFS:   arr <= wdata16;
                    timerPkg::CCR1_OFS:  ccrQ[0] <= wdata16;
                    timerPkg::CCR2_OFS:  ccrQ[1] <= wdata16;
                    timerPkg::CCR3_OFS:  ccrQ[2] <= wdata16;
                    timerPkg::CCR4_OFS:  ccrQ[3] <= wdata16;
                    default: ;  // CNT and EGR act as strobes
                endcase
            end
            if (updateEvent) begin
                uif <= 1'b1;  // hardware set beats a software clear
            end
        end
    end

    always_comb begin
        cfg.enable = cr1[timerPkg::CEN_BIT];
        cfg.dir = cr1[timerPkg::DIR_BIT];
        cfg.ckd = cr1[timerPkg::CKD_LSB +: 2];
        cfg.psc = psc;
        cfg.arr = arr;
        cfg.cntLoad = wrEn && (bus.addr == timerPkg::CNT_OFS);
        cfg.cntLoadValue = wdata16;
        cfg.forceUpdate = wrEn && (bus.addr == timerPkg::EGR_OFS) && wdata16[timerPkg::UG_BIT];
    end

    always_comb begin
        rdValue = '0;
        case (bus.addr)
            timerPkg::CR1_OFS:   rdValue = cr1;
            timerPkg::DIER_OFS:  rdValue = dier;
            timerPkg::SR_OFS:    rdValue[timerPkg::UIF_BIT] = uif;
            timerPkg::CCMR1_OFS: rdValue = ccmr1;
            timerPkg::CCMR2_OFS: rdValue = ccmr2;
            timerPkg::CCER_OFS:  rdValue = ccerQ;
            timerPkg::CNT_OFS:   rdValue = cnt;  // live count
            timerPkg::PSC_OFS:   rdValue = psc;
            timerPkg::ARR_OFS:   rdValue = arr;
            timerPkg::CCR1_OFS:  rdValue = ccrQ[0];
            timerPkg::CCR2_OFS:  rdValue = ccrQ[1];
            timerPkg::CCR3_OFS:  rdValue = ccrQ[2];
            timerPkg::CCR4_OFS:  rdValue = ccrQ[3];
            default: ;
        endcase
    end

    assign bus.rdata = rdEn ? {{(apbPkg::DATA_WIDTH-W){1'b0}}, rdValue} : '0;
    assign bus.slvErr = 1'b0;  // every offset inside the window is legal

    assign ccmr = {ccmr2, ccmr1};
    assign ccer = ccerQ;
    assign ccr = {ccrQ[3], ccrQ[2], ccrQ[1], ccrQ[0]};
    assign interrupt = dier[timerPkg::UIE_BIT] && uif;

endmodule

`default_nettype wire

// File: timer/timerUnit.sv
`timescale 1ns/100ps
`default_nettype none

module timerUnit #(
    parameter int channelCount = 4
) (
    input  wire       io_apb_PCLK,
    input  wire       io_apb_PRESET,
    apbSlaveIf.timer  bus,
    output wire [3:0] ch,
    output wire       interrupt
);

    timerPkg::timerCfgT cfg;
    logic [15:0]        cnt;
    logic               updateEvent;
    logic [31:0]        ccmr;
    logic [15:0]        ccer;
    logic [63:0]        ccr;

    assign bus.ready = 1'b1;  // no wait states

    timerRegs regs (
        .io_apb_PCLK   (io_apb_PCLK),
        .io_apb_PRESET (io_apb_PRESET),
        .cnt           (cnt),
        .updateEvent   (updateEvent),
        .bus           (bus),
        .cfg           (cfg),
        .ccmr          (ccmr),
        .ccer          (ccer),
        .ccr           (ccr),
        .interrupt     (interrupt)
    );

    timerCounter counter (
        .io_apb_PCLK   (io_apb_PCLK),
        .io_apb_PRESET (io_apb_PRESET),
        .cfg           (cfg),
        .cnt           (cnt),
        .updateEvent   (updateEvent)
    );

    timerCompareOut #(
        .channelCount (channelCount)
    ) compare (
        .cnt  (cnt),
        .dir  (cfg.dir),
        .ccmr (ccmr),
        .ccer (ccer),
        .ccr  (ccr),
        .ch   (ch)
    );

endmodule

`default_nettype wire

// File: rtl/apbSlotRouter.sv
`timescale 1ns/100ps
`default_nettype none

module apbSlotRouter (
    input  wire                           io_apb_PCLK,
    input  wire                           io_apb_PRESET,
    input  wire  [apbPkg::ADDR_WIDTH-1:0] paddr,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire  [apbPkg::DATA_WIDTH-1:0] pwdata,
    output logic [apbPkg::DATA_WIDTH-1:0] prdata,
    output logic                          pready,
    output logic                          pslverr,
    apbSlaveIf.router                     tim2Bus,
    apbSlaveIf.router                     tim3Bus
);

    apbPkg::slotT slot;
    apbPkg::slotT slotQ;  // slot of the transfer in flight

    assign slot = paddr[apbPkg::SLOT_MSB:apbPkg::SLOT_LSB];

    assign tim2Bus.sel = psel && (slot == apbPkg::TIM2_SLOT);
    assign tim2Bus.addr = paddr[apbPkg::REG_ADDR_WIDTH+1:2];
    assign tim2Bus.enable = penable;
    assign tim2Bus.write = pwrite;
    assign tim2Bus.wdata = pwdata;

    assign tim3Bus.sel = psel && (slot == apbPkg::TIM3_SLOT);
    assign tim3Bus.addr = paddr[apbPkg::REG_ADDR_WIDTH+1:2];
    assign tim3Bus.enable = penable;
    assign tim3Bus.write = pwrite;
    assign tim3Bus.wdata = pwdata;

    // captured at the edge closing the setup phase
    always_ff @(posedge io_apb_PCLK or posedge io_apb_PRESET) begin
        if (io_apb_PRESET) begin
            slotQ <= '0;
        end else if (psel && !penable) begin
            slotQ <= slot;
        end
    end

    always_comb begin
        prdata = '0;
        pready = 1'b1;
        pslverr = 1'b0;
        case (slotQ)
            apbPkg::TIM2_SLOT: begin
                prdata = tim2Bus.rdata;
                pready = tim2Bus.ready;
                pslverr = tim2Bus.slvErr;
            end
            apbPkg::TIM3_SLOT: begin
                prdata = tim3Bus.rdata;
                pready = tim3Bus.ready;
                pslverr = tim3Bus.slvErr;
            end
            default: pslverr = psel && penable;  // unmapped slot
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/apbTimerSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module apbTimerSubsystem #(
    parameter int channelCount = 4
) (
    input  wire                          io_apb_PCLK,
    input  wire                          io_apb_PRESET,
    input  wire [apbPkg::ADDR_WIDTH-1:0] paddr,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [apbPkg::DATA_WIDTH-1:0] pwdata,
    output wire [apbPkg::DATA_WIDTH-1:0] prdata,
    output wire                          pready,
    output wire                          pslverr,
    output wire [3:0]                    tim2Ch,
    output wire                          tim2Interrupt,
    output wire [3:0]                    tim3Ch,
    output wire                          tim3Interrupt
);

    apbSlaveIf tim2Bus ();
    apbSlaveIf tim3Bus ();

    apbSlotRouter router (
        .io_apb_PCLK   (io_apb_PCLK),
        .io_apb_PRESET (io_apb_PRESET),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .tim2Bus       (tim2Bus.router),
        .tim3Bus       (tim3Bus.router)
    );

    timerUnit #(
        .channelCount (channelCount)
    ) tim2Unit (
        .io_apb_PCLK   (io_apb_PCLK),
        .io_apb_PRESET (io_apb_PRESET),
        .bus           (tim2Bus.timer),
        .ch            (tim2Ch),
        .interrupt     (tim2Interrupt)
    );

    timerUnit #(
        .channelCount (channelCount)
    ) tim3Unit (
        .io_apb_PCLK   (io_apb_PCLK),
        .io_apb_PRESET (io_apb_PRESET),
        .bus           (tim3Bus.timer),
        .ch            (tim3Ch),
        .interrupt     (tim3Interrupt)
    );

endmodule

`default_nettype wire

// File: dv/tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
    parameter real periodNs    = 8.0,
    parameter int  resetCycles = 2
) (
    output logic io_apb_PCLK,
    output logic io_apb_PRESET
);

    initial begin
        io_apb_PCLK = 1'b0;
        forever #(periodNs / 2.0) io_apb_PCLK = !io_apb_PCLK;
    end

    initial begin
        io_apb_PRESET = 1'b1;
        repeat (resetCycles) @(posedge io_apb_PCLK);
        io_apb_PRESET <= 1'b0;  // released on a rising edge
    end

endmodule

`default_nettype wire

// File: dv/tbApbTimer.sv
`timescale 1ns/100ps
`default_nettype none

module tbApbTimer;

    localparam int TRANSFER_CYCLES = 3;  // setup, access, idle
    localparam int MAX_EVENT_CYCLES = 8 * 3 * 4 + 1;  // largest ARR+1, PSC+1 and divider
    localparam int RESET_CYCLES = 2 * 32 * TRANSFER_CYCLES + 4;
    localparam int REG_CYCLES = 2 * 2 * (14 + 64) * TRANSFER_CYCLES;
    localparam int DECODE_CYCLES = 17 * TRANSFER_CYCLES;
    localparam int COUNT_CYCLES = 2 * 2 * (14 * TRANSFER_CYCLES + MAX_EVENT_CYCLES);
    localparam int PWM_CYCLES = 2 * 8 * 10 * TRANSFER_CYCLES;
    localparam int CYCLE_LIMIT =
        2 * (RESET_CYCLES + REG_CYCLES + DECODE_CYCLES + COUNT_CYCLES + PWM_CYCLES);

    logic        io_apb_PCLK;
    logic        io_apb_PRESET;
    logic [15:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire  [3:0]  tim2Ch;
    wire  [3:0]  tim3Ch;
    wire         tim2Interrupt;
    wire         tim3Interrupt;
    logic [31:0] rngState = 32'h3899;
    logic [15:0] expReg [2][32];  // register model, one row per timer
    int unsigned cycleCount = 0;

    tbClock clockGen (
        .io_apb_PCLK   (io_apb_PCLK),
        .io_apb_PRESET (io_apb_PRESET)
    );

    apbTimerSubsystem dut_i (
        .io_apb_PCLK   (io_apb_PCLK),
        .io_apb_PRESET (io_apb_PRESET),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .tim2Ch        (tim2Ch),
        .tim2Interrupt (tim2Interrupt),
        .tim3Ch        (tim3Ch),
        .tim3Interrupt (tim3Interrupt)
    );

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [15:0] regAddr(input logic [3:0] slot, input logic [4:0] ofs);
        return {slot, 5'b0, ofs, 2'b0};
    endfunction

    function automatic int divRatio(input int ckd);
        return (ckd == 1) ? 2 : (ckd == 2) ? 4 : 1;
    endfunction

    function automatic logic interruptOf(input int t);
        return (t == 0) ? tim2Interrupt : tim3Interrupt;
    endfunction

    function automatic logic [3:0] chOf(input int t);
        return (t == 0) ? tim2Ch : tim3Ch;
    endfunction

    // mode 6 or 7 with enable, then polarity
    function automatic logic [3:0] expectedPwm(input logic dir, input logic [15:0] cnt,
            input logic [31:0] ccmr, input logic [15:0] ccer, input logic [3:0][15:0] ccr);
        logic [3:0] level;
        logic [2:0] mode;
        logic       below;
        logic       raw;
        for (int i = 0; i < 4; i++) begin
            mode = ccmr[8*i+4 +: 3];
            below = dir ? (cnt <= ccr[i]) : (cnt < ccr[i]);
            raw = 1'b0;
            if (ccer[4*i] && mode == 3'd6) raw = below;
            if (ccer[4*i] && mode == 3'd7) raw = !below;
            level[i] = raw ^ ccer[4*i+1];
        end
        return level;
    endfunction

    task automatic stopOnFailure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic checkHex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnFailure();
        end
    endtask

    task automatic apbTransfer(input logic write, input logic [15:0] addr,
            input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
        @(posedge io_apb_PCLK);
        paddr <= addr;
        pwrite <= write;
        pwdata <= wdata;
        psel <= 1'b1;
        penable <= 1'b0;
        @(posedge io_apb_PCLK);
        penable <= 1'b1;
        @(negedge io_apb_PCLK);  // access phase, response stable
        checkHex("pready", {31'b0, pready}, 32'h1);
        rdata = prdata;
        err = pslverr;
        @(posedge io_apb_PCLK);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic regWrite(input int t, input logic [4:0] ofs, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b1, regAddr(4'(t + 1), ofs), data, rdata, err);
        checkHex("pslverr", {31'b0, err}, 32'h0);
    endtask

    task automatic regExpect(input int t, input logic [4:0] ofs, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b0, regAddr(4'(t + 1), ofs), 32'h0, rdata, err);
        checkHex("pslverr", {31'b0, err}, 32'h0);
        checkHex($sformatf("prdata TIM%0d offset %0d", t + 2, ofs), rdata, exp);
    endtask

    task automatic checkAllRegs(input int t);
        for (int ofs = 0; ofs < 32; ofs++) begin
            regExpect(t, 5'(ofs), {16'b0, expReg[t][ofs]});
        end
    endtask

    task automatic testRegisters();
        logic [4:0]  implemented [9] = '{6, 7, 8, 10, 11, 13, 14, 15, 16};
        logic [4:0]  unused [5] = '{1, 2, 12, 17, 31};  // no register behind these
        logic [31:0] data;
        for (int round = 0; round < 2; round++) begin
            for (int t = 0; t < 2; t++) begin
                foreach (implemented[i]) begin
                    data = nextRandom();
                    regWrite(t, implemented[i], data);
                    expReg[t][implemented[i]] = data[15:0];
                end
                foreach (unused[i]) regWrite(t, unused[i], nextRandom());
                checkAllRegs(0);  // also shows the other timer untouched
                checkAllRegs(1);
            end
        end
    endtask

    task automatic testDecode();
        logic [31:0] rdata;
        logic        err;
        for (int s = 0; s < 16; s++) begin
            apbTransfer(1'b0, regAddr(4'(s), timerPkg::PSC_OFS), 32'h0, rdata, err);
            if (s == 1 || s == 2) begin
                checkHex("pslverr", {31'b0, err}, 32'h0);
                checkHex("prdata", rdata, {16'b0, expReg[s - 1][timerPkg::PSC_OFS]});
            end else begin
                checkHex("pslverr", {31'b0, err}, 32'h1);
                checkHex("prdata", rdata, 32'h0);
            end
        end
        apbTransfer(1'b1, regAddr(4'(3 + nextRandom() % 13), timerPkg::PSC_OFS), nextRandom(),
                    rdata, err);
        checkHex("pslverr", {31'b0, err}, 32'h1);
    endtask

    // interrupt must stay low until exactly the last sampled cycle
    task automatic expectInterruptAfter(input int t, input int cycles);
        for (int c = 0; c <= cycles; c++) begin
            @(negedge io_apb_PCLK);
            checkHex($sformatf("tim%0dInterrupt cycle %0d", t + 2, c), {31'b0, interruptOf(t)},
                     (c == cycles) ? 32'h1 : 32'h0);
        end
    endtask

    task automatic testUpCount(input int t);
        int          psc;
        int          arr;
        int          ckd;
        logic [15:0] load;
        psc = nextRandom() % 3;
        arr = 2 + nextRandom() % 6;
        ckd = nextRandom() % 4;
        regWrite(t, timerPkg::PSC_OFS, 32'(psc));
        regWrite(t, timerPkg::ARR_OFS, 32'(arr));
        regWrite(t, timerPkg::DIER_OFS, 32'h1);
        regWrite(t, timerPkg::CNT_OFS, 32'h0);
        regWrite(t, timerPkg::SR_OFS, 32'h0);
        regWrite(t, timerPkg::CR1_OFS, 32'((ckd << 8) | 1));
        expectInterruptAfter(t, (arr + 1) * (psc + 1) * divRatio(ckd) + 1);
        regWrite(t, timerPkg::CR1_OFS, 32'h0);  // stop so no new event races the clear
        regWrite(t, timerPkg::SR_OFS, 32'h0);
        @(negedge io_apb_PCLK);
        checkHex($sformatf("tim%0dInterrupt", t + 2), {31'b0, interruptOf(t)}, 32'h0);
        load = 16'(1 + nextRandom() % 100);
        regWrite(t, timerPkg::CNT_OFS, {16'b0, load});
        regExpect(t, timerPkg::CNT_OFS, {16'b0, load});
        regWrite(t, timerPkg::EGR_OFS, 32'h1);
        regExpect(t, timerPkg::CNT_OFS, 32'h0);
        regExpect(t, timerPkg::SR_OFS, 32'h1);
        @(negedge io_apb_PCLK);
        checkHex($sformatf("tim%0dInterrupt", t + 2), {31'b0, interruptOf(t)}, 32'h1);
        regWrite(t, timerPkg::SR_OFS, 32'h0);
    endtask

    task automatic testDownCount(input int t);
        int psc;
        int ckd;
        int load;
        int arr;
        int period;
        psc = nextRandom() % 3;
        ckd = nextRandom() % 4;
        load = 1 + nextRandom() % 5;
        arr = load + 3 + nextRandom() % 3;
        period = (psc + 1) * divRatio(ckd);
        regWrite(t, timerPkg::PSC_OFS, 32'(psc));
        regWrite(t, timerPkg::ARR_OFS, 32'(arr));
        regWrite(t, timerPkg::CNT_OFS, 32'(load));
        regWrite(t, timerPkg::CR1_OFS, 32'((ckd << 8) | 32'h11));
        expectInterruptAfter(t, (load + 1) * period + 1);
        // reload edge lies three edges before the read sample
        regExpect(t, timerPkg::CNT_OFS, 32'(arr - 3 / period));
        regWrite(t, timerPkg::CR1_OFS, 32'h0);
        regWrite(t, timerPkg::SR_OFS, 32'h0);
    endtask

    task automatic testPwm(input int t);
        logic              dir;
        logic [15:0]       cnt;
        logic [31:0]       ccmr;
        logic [15:0]       ccer;
        logic [3:0][15:0]  ccr;
        logic [31:0]       r;
        for (int it = 0; it < 8; it++) begin
            r = nextRandom();
            dir = r[0];
            cnt = {12'b0, r[7:4]};  // small values so CNT meets CCR often
            ccmr = nextRandom();
            for (int i = 0; i < 4; i++) begin
                r = nextRandom();
                ccmr[8*i+4 +: 3] = (r[1:0] != 2'b0) ? {2'b11, r[2]} : r[5:3];
                ccr[i] = {12'b0, r[11:8]};
            end
            ccer = 16'(nextRandom());
            regWrite(t, timerPkg::CR1_OFS, {27'b0, dir, 4'b0});  // CEN stays 0
            regWrite(t, timerPkg::CNT_OFS, {16'b0, cnt});
            regWrite(t, timerPkg::CCMR1_OFS, {16'b0, ccmr[15:0]});
            regWrite(t, timerPkg::CCMR2_OFS, {16'b0, ccmr[31:16]});
            regWrite(t, timerPkg::CCER_OFS, {16'b0, ccer});
            for (int i = 0; i < 4; i++) regWrite(t, 5'(13 + i), {16'b0, ccr[i]});
            @(negedge io_apb_PCLK);
            checkHex($sformatf("tim%0dCh", t + 2), {28'b0, chOf(t)},
                     {28'b0, expectedPwm(dir, cnt, ccmr, ccer, ccr)});
        end
    endtask

    always @(posedge io_apb_PCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            stopOnFailure();
        end
    end

    initial begin
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        for (int t = 0; t < 2; t++) begin
            for (int ofs = 0; ofs < 32; ofs++) expReg[t][ofs] = 16'h0;
            expReg[t][timerPkg::ARR_OFS] = 16'hFFFF;
        end
        @(negedge io_apb_PRESET);
        @(negedge io_apb_PCLK);
        checkHex("pready", {31'b0, pready}, 32'h1);
        checkHex("pslverr", {31'b0, pslverr}, 32'h0);
        checkHex("tim2Interrupt/tim3Interrupt", {30'b0, tim2Interrupt, tim3Interrupt}, 32'h0);
        checkHex("tim2Ch/tim3Ch", {24'b0, tim2Ch, tim3Ch}, 32'h0);
        checkAllRegs(0);
        checkAllRegs(1);
        testRegisters();
        testDecode();
        for (int t = 0; t < 2; t++) begin
            testUpCount(t);
            testDownCount(t);
            testPwm(t);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/apbPkg.sv
common/timerPkg.sv
common/apbSlaveIf.sv
timer/timerCounter.sv
timer/timerCompareOut.sv
timer/timerRegs.sv
timer/timerUnit.sv
rtl/apbSlotRouter.sv
rtl/apbTimerSubsystem.sv
dv/tbClock.sv
dv/tbApbTimer.sv
